/* list.f */
+incdir+design
design/fb_bus_pkg.sv
design/fb_map_pkg.sv
design/fb_addr_decode.sv
design/fb_router.sv
design/fb_mem_slave.sv
design/fb_subsys_top.sv
test/fb_router_chk.sv
test/fb_monitor.sv
test/fb_tb.sv

/* Bender.yml */
package:
  name: fb_subsys

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/fb_bus_pkg.sv
      - design/fb_map_pkg.sv
      - design/fb_addr_decode.sv
      - design/fb_router.sv
      - design/fb_mem_slave.sv
      - design/fb_subsys_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - test/fb_router_chk.sv
      - test/fb_monitor.sv
      - test/fb_tb.sv

/* test/fb_tb.sv */
// ******************************
// Random commands with back-pressure
// Fixed seed, run bounded by cycle count
// ******************************
`timescale 1ns/1ps
`include "fb_defines.svh"

module fb_tb;

   import fb_bus_pkg::*;

   localparam int NUM_CMDS   = 600;
   // Worst latency plus back-pressure per command
   localparam int MAX_CYCLES = NUM_CMDS * 40;

   logic    clk;
   logic    rst;
   logic    a_valid;
   logic    a_ready;
   fb_req_t a_req;
   logic    b_valid;
   logic    b_ready;
   fb_rsp_t b_rsp;
   int      errors;
   int      checks;
   int      responses;
   int      assert_fails;
   int      issued;
   int      cycles;

   fb_subsys_top dut0
   (
      .clk     (clk),
      .rst     (rst),
      .a_valid (a_valid),
      .a_ready (a_ready),
      .a_req   (a_req),
      .b_valid (b_valid),
      .b_ready (b_ready),
      .b_rsp   (b_rsp)
   );

   fb_monitor mon0
   (
      .clk       (clk),
      .rst       (rst),
      .a_valid   (a_valid),
      .a_ready   (a_ready),
      .a_req     (a_req),
      .b_valid   (b_valid),
      .b_ready   (b_ready),
      .b_rsp     (b_rsp),
      .errors    (errors),
      .checks    (checks),
      .responses (responses)
   );

   bind fb_router fb_router_chk chk0
   (
      .clk         (clk),
      .rst         (rst),
      .pending     (pending_q),
      .sel         (sel),
      .bus_b_valid (bus_b_valid),
      .bus_a_valid (bus_a_valid)
   );

   function automatic fb_req_t random_req();
      fb_req_t r;
      r = '0;
      r.addr[9:0] = $urandom_range(1023);
      // Upper bits alias, so half the commands carry noise there
      if ($urandom_range(1) == 1)
      begin
         r.addr[`FB_AW-1:10] = $urandom;
      end
      r.wdata = $urandom;
      // About 40% reads
      if ($urandom_range(99) < 40)
      begin
         r.wmsk = '0;
      end
      else
      begin
         r.wmsk = $urandom_range(1, (1 << `FB_MW) - 1);
      end
      r.exc = $urandom_range(3);
      return r;
   endfunction

   initial
   begin
      clk = 1'b0;
      forever
      begin
         #4 clk = ~clk;
      end
   end

   initial
   begin
      rst     = 1'b1;
      a_valid = 1'b0;
      a_req   = '0;
      b_ready = 1'b0;
      issued  = 0;
      cycles  = 0;
      void'($urandom(59400));
      repeat (8) @(posedge clk);
      rst <= 1'b0;
      while (responses < NUM_CMDS && cycles < MAX_CYCLES)
      begin
         @(posedge clk);
         cycles++;
         // b_ready low about 30% of cycles
         b_ready <= ($urandom_range(99) >= 30);
         // New command once the previous one has transferred
         if (!a_valid || a_ready)
         begin
            if (issued < NUM_CMDS && $urandom_range(9) != 0)
            begin
               a_req   <= random_req();
               a_valid <= 1'b1;
               issued++;
            end
            else
            begin
               a_valid <= 1'b0;
            end
         end
      end
      // Monitor and assertions settle on the last edge
      @(negedge clk);
      assert_fails = dut0.u_router.chk0.fails;
      if (responses < NUM_CMDS)
      begin
         $display("Timeout: only %0d of %0d responses after %0d cycles",
                  responses, NUM_CMDS, cycles);
      end
      $display("Responses %0d, checks %0d, errors %0d, assertion failures %0d",
               responses, checks, errors, assert_fails);
      if (responses == NUM_CMDS && errors == 0 && assert_fails == 0)
      begin
         $display("Result: PASSED");
      end
      else
      begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule

/* test/fb_monitor.sv */
// ******************************
// Memory model and response checks
// Assumes at most one command in flight
// ******************************
`timescale 1ns/1ps
`include "fb_defines.svh"

module fb_monitor
(
   input  logic                clk,
   input  logic                rst,
   input  logic                a_valid,
   input  logic                a_ready,
   input  fb_bus_pkg::fb_req_t a_req,
   input  logic                b_valid,
   input  logic                b_ready,
   input  fb_bus_pkg::fb_rsp_t b_rsp,
   output int                  errors,
   output int                  checks,
   output int                  responses
);

   import fb_bus_pkg::*;

   logic [`FB_DW-1:0] model [`FB_NBUS][`FB_MEM_WORDS];
   fb_rsp_t           expect_q [$];
   fb_rsp_t           last_rsp;
   logic              last_stall;
   logic              in_flight;
   logic              seen_valid;
   logic              after_reset;
   int                bus;
   int                acc_cyc;
   int                cyc;

   initial
   begin
      errors    = 0;
      checks    = 0;
      responses = 0;
      cyc       = 0;
   end

   task automatic report_error(input string msg);
      errors++;
      $display("[ERROR] %0t: %s", $time, msg);
   endtask

   // Masked write into the model, expected word read back after it
   task automatic take_command(input fb_req_t req);
      int      b;
      int      w;
      fb_rsp_t r;
      b = req.addr[`FB_SEL_LSB +: 2];
      w = req.addr[7:2];
      for (int k = 0; k < `FB_DW/8; k++)
      begin
         if (req.wmsk[k])
         begin
            model[b][w][8*k +: 8] = req.wdata[8*k +: 8];
         end
      end
      r.rdata = model[b][w];
      r.exc   = req.exc;
      expect_q.push_back(r);
      bus        = b;
      acc_cyc    = cyc;
      in_flight  = 1'b1;
      seen_valid = 1'b0;
   endtask

   task automatic check_response;
      fb_rsp_t want;
      responses++;
      checks++;
      in_flight = 1'b0;
      if (expect_q.size() == 0)
      begin
         report_error("Response taken with nothing expected");
      end
      else
      begin
         want = expect_q.pop_front();
         if (b_rsp !== want)
         begin
            report_error($sformatf("rdata %h exc %0d, expected rdata %h exc %0d",
                                   b_rsp.rdata, b_rsp.exc, want.rdata, want.exc));
         end
      end
   endtask

   // All sampling uses values from before the edge
   always @(posedge clk)
   begin
      cyc++;
      if (rst)
      begin
         for (int b = 0; b < `FB_NBUS; b++)
         begin
            for (int w = 0; w < `FB_MEM_WORDS; w++)
            begin
               model[b][w] = '0;
            end
         end
         expect_q.delete();
         in_flight   = 1'b0;
         seen_valid  = 1'b0;
         last_stall  = 1'b0;
         after_reset = 1'b1;
      end
      else
      begin
         // Idle fabric right after reset
         if (after_reset)
         begin
            checks++;
            after_reset = 1'b0;
            if (!a_ready || b_valid)
            begin
               report_error($sformatf("after reset a_ready %b b_valid %b", a_ready, b_valid));
            end
         end
         // Stalled response must hold
         if (last_stall)
         begin
            checks++;
            if (!b_valid || b_rsp !== last_rsp)
            begin
               report_error("response dropped or changed while b_ready low");
            end
         end
         if (b_valid && !in_flight)
         begin
            report_error("b_valid high with no outstanding command");
         end
         if (in_flight && a_ready)
         begin
            report_error("a_ready high with a command outstanding");
         end
         // First sample of b_valid is one edge after its rise
         if (b_valid && in_flight && !seen_valid)
         begin
            checks++;
            seen_valid = 1'b1;
            if (cyc - acc_cyc != bus + 2)
            begin
               report_error($sformatf("bus %0d answered after %0d cycles, expected %0d",
                                      bus, cyc - acc_cyc - 1, bus + 1));
            end
         end
         if (b_valid && b_ready)
         begin
            check_response();
         end
         if (a_valid && a_ready)
         begin
            take_command(a_req);
         end
         last_stall = b_valid && !b_ready;
         last_rsp   = b_rsp;
      end
   end

endmodule

/* test/fb_router_chk.sv */
// ******************************
// Router exclusivity assertions
// Bound into every fb_router
// ******************************
`timescale 1ns/1ps
`include "fb_defines.svh"

module fb_router_chk
(
   input logic                clk,
   input logic                rst,
   input logic [`FB_NBUS-1:0] pending,
   input fb_map_pkg::fb_sel_t sel,
   input logic [`FB_NBUS-1:0] bus_b_valid,
   input logic [`FB_NBUS-1:0] bus_a_valid
);

   int fails = 0;

   // At most one bus cycle open
   a_pending: assert property (@(posedge clk) disable iff (rst) $onehot0(pending))
   else
   begin
      fails++;
      $error("More than one pending flag set: %b", pending);
   end

   // Decoder always names exactly one bus
   a_sel: assert property (@(posedge clk) disable iff (rst) $onehot(sel))
   else
   begin
      fails++;
      $error("Bus select not one-hot: %b", sel);
   end

   // A slave response needs its bus pending
   a_bvalid: assert property (@(posedge clk) disable iff (rst)
                              (bus_b_valid & ~pending) == '0)
   else
   begin
      fails++;
      $error("Response valid on a bus with no pending flag: %b", bus_b_valid);
   end

   // Commands go to one bus only
   a_avalid: assert property (@(posedge clk) disable iff (rst) $onehot0(bus_a_valid))
   else
   begin
      fails++;
      $error("Command valid on more than one bus: %b", bus_a_valid);
   end

endmodule

/* design/fb_subsys_top.sv */
// ******************************
// Decoder, router and four slaves
// Slave i answers after 1 + i cycles
// ******************************
`timescale 1ns/1ps
`include "fb_defines.svh"

module fb_subsys_top
(
   input  logic                clk,
   input  logic                rst,
   input  logic                a_valid,
   output logic                a_ready,
   input  fb_bus_pkg::fb_req_t a_req,
   output logic                b_valid,
   input  logic                b_ready,
   output fb_bus_pkg::fb_rsp_t b_rsp
);

   import fb_bus_pkg::*;
   import fb_map_pkg::*;

   fb_sel_t             sel;
   logic [`FB_NBUS-1:0] bus_a_valid;
   logic [`FB_NBUS-1:0] bus_a_ready;
   fb_req_t             bus_req [`FB_NBUS];
   logic [`FB_NBUS-1:0] bus_b_valid;
   logic [`FB_NBUS-1:0] bus_b_ready;
   fb_rsp_t             bus_rsp [`FB_NBUS];

   // Address map
   fb_addr_decode u_decode
   (
      .addr (a_req.addr),
      .sel  (sel)
   );

   // Bus-cycle tracking and steering
   fb_router u_router
   (
      .clk         (clk),
      .rst         (rst),
      .a_valid     (a_valid),
      .a_ready     (a_ready),
      .a_req       (a_req),
      .b_valid     (b_valid),
      .b_ready     (b_ready),
      .b_rsp       (b_rsp),
      .sel         (sel),
      .bus_a_valid (bus_a_valid),
      .bus_a_ready (bus_a_ready),
      .bus_req     (bus_req),
      .bus_b_valid (bus_b_valid),
      .bus_b_ready (bus_b_ready),
      .bus_rsp     (bus_rsp)
   );

   // One slave per bus, latency grows with the index
   for (genvar i = 0; i < `FB_NBUS; i++)
   begin : slave_g
      fb_mem_slave #(.LATENCY(1 + i)) u_slave
      (
         .clk     (clk),
         .rst     (rst),
         .a_valid (bus_a_valid[i]),
         .a_ready (bus_a_ready[i]),
         .req     (bus_req[i]),
         .b_valid (bus_b_valid[i]),
         .b_ready (bus_b_ready[i]),
         .rsp     (bus_rsp[i])
      );
   end

endmodule

/* design/fb_mem_slave.sv */
// ******************************
// Word memory with fixed latency
// LATENCY must be 1 or more
// ******************************
`timescale 1ns/1ps
`include "fb_defines.svh"

module fb_mem_slave
#(
   parameter int LATENCY = 1
)
(
   input  logic                clk,
   input  logic                rst,
   // Command channel
   input  logic                a_valid,
   output logic                a_ready,
   input  fb_bus_pkg::fb_req_t req,
   // Response channel
   output logic                b_valid,
   input  logic                b_ready,
   output fb_bus_pkg::fb_rsp_t rsp
);

   localparam int IDX_W = $clog2(`FB_MEM_WORDS);
   localparam int CNT_W = $clog2(LATENCY + 1);

   logic [`FB_DW-1:0]    mem [`FB_MEM_WORDS];
   logic [IDX_W-1:0]     idx;
   logic [IDX_W-1:0]     idx_q;
   logic [CNT_W-1:0]     cnt_q;
   logic                 busy_q;
   logic                 b_valid_q;
   logic [`FB_DW-1:0]    rdata_q;
   logic [`FB_EXC_W-1:0] exc_q;
   logic                 accept;
   logic                 expire;

   // Word index from addr[7:2]
   assign idx = req.addr[2 +: IDX_W];

   // Idle slave takes one command
   assign a_ready = ~busy_q;
   assign accept  = a_valid & a_ready;

   // Last cycle of the countdown
   assign expire = busy_q & ~b_valid_q & (cnt_q == CNT_W'(1));

   // Control state
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         busy_q    <= 1'b0;
         b_valid_q <= 1'b0;
         cnt_q     <= '0;
      end
      else if (accept)
      begin
         busy_q <= 1'b1;
         cnt_q  <= CNT_W'(LATENCY);
      end
      else if (expire)
      begin
         b_valid_q <= 1'b1;
         cnt_q     <= '0;
      end
      else if (busy_q & ~b_valid_q)
      begin
         cnt_q <= cnt_q - CNT_W'(1);
      end
      else if (b_valid_q & b_ready)
      begin
         // Idle again after the response edge
         b_valid_q <= 1'b0;
         busy_q    <= 1'b0;
      end
   end

   // Memory starts out zeroed
   // Masked bytes written on accept
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         for (int w = 0; w < `FB_MEM_WORDS; w++)
         begin
            mem[w] <= '0;
         end
      end
      else if (accept)
      begin
         for (int b = 0; b < `FB_MW; b++)
         begin
            if (req.wmsk[b])
            begin
               mem[idx][8*b +: 8] <= req.wdata[8*b +: 8];
            end
         end
      end
   end

   // Payload latched, held until the response is taken
   always_ff @(posedge clk)
   begin
      if (accept)
      begin
         idx_q <= idx;
         exc_q <= req.exc;
      end
      // Word already holds any write from the accept edge
      if (expire)
      begin
         rdata_q <= mem[idx_q];
      end
   end

   assign b_valid = b_valid_q;
   assign rsp = '{rdata: rdata_q, exc: exc_q};

endmodule

/* design/fb_router.sv */
// ******************************
// Routes commands to four buses
// Only one bus cycle open at a time
// ******************************
`timescale 1ns/1ps
`include "fb_defines.svh"

module fb_router
(
   input  logic                 clk,
   input  logic                 rst,
   // Core-side command channel
   input  logic                 a_valid,
   output logic                 a_ready,
   input  fb_bus_pkg::fb_req_t  a_req,
   // Core-side response channel
   output logic                 b_valid,
   input  logic                 b_ready,
   output fb_bus_pkg::fb_rsp_t  b_rsp,
   // Decoded target
   input  fb_map_pkg::fb_sel_t  sel,
   // Slave command channels
   output logic [`FB_NBUS-1:0]  bus_a_valid,
   input  logic [`FB_NBUS-1:0]  bus_a_ready,
   output fb_bus_pkg::fb_req_t  bus_req [`FB_NBUS],
   // Slave response channels
   input  logic [`FB_NBUS-1:0]  bus_b_valid,
   output logic [`FB_NBUS-1:0]  bus_b_ready,
   input  fb_bus_pkg::fb_rsp_t  bus_rsp [`FB_NBUS]
);

   import fb_bus_pkg::*;

   logic [`FB_NBUS-1:0] pending_q;
   logic [`FB_NBUS-1:0] cmd_hs;
   logic [`FB_NBUS-1:0] rsp_hs;
   logic [`FB_NBUS-1:0] may_accept;
   logic [`FB_NBUS-1:0] a_ready_bus;
   fb_rsp_t             rsp_merge;

   // Transfers on each slave bus
   assign cmd_hs = bus_a_valid & bus_a_ready;
   assign rsp_hs = bus_b_valid & bus_b_ready;

   // Pending flag per bus
   // Set by a command, cleared by its response
   // A same-edge command keeps the flag set
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         pending_q <= '0;
      end
      else
      begin
         pending_q <= cmd_hs | (pending_q & ~rsp_hs);
      end
   end

   // A bus may take a command when the fabric is idle
   // or when it already owns the open cycle
   always_comb
   begin
      for (int i = 0; i < `FB_NBUS; i++)
      begin
         may_accept[i] = (pending_q == '0) | pending_q[i];
      end
   end

   // Valid goes to the selected bus only
   assign bus_a_valid = sel & may_accept & {`FB_NBUS{a_valid}};

   // Ready comes back from the selected bus only
   assign a_ready_bus = sel & may_accept & bus_a_ready;
   assign a_ready = |a_ready_bus;

   // Payload fans out to every bus
   always_comb
   begin
      for (int i = 0; i < `FB_NBUS; i++)
      begin
         bus_req[i] = a_req;
      end
   end

   // Responses merged by OR over pending-masked payloads
   always_comb
   begin
      rsp_merge = '0;
      for (int i = 0; i < `FB_NBUS; i++)
      begin
         rsp_merge = rsp_merge | ({$bits(fb_rsp_t){pending_q[i]}} & bus_rsp[i]);
      end
   end

   assign b_rsp = rsp_merge;

   // Only the pending bus can raise the core-side valid
   assign b_valid = |(pending_q & bus_b_valid);

   // Ready goes back to the pending bus only
   assign bus_b_ready = pending_q & {`FB_NBUS{b_ready}};

endmodule

/* design/fb_addr_decode.sv */
// ******************************
// Address to one-hot bus select
// Bits above the bus index alias
// ******************************
`timescale 1ns/1ps
`include "fb_defines.svh"

module fb_addr_decode
(
   input  logic [`FB_AW-1:0] addr,
   output fb_map_pkg::fb_sel_t sel
);

   import fb_map_pkg::*;

   localparam int IDX_W = $bits(fb_bus_idx_t);

   fb_bus_idx_t bus_idx;

   // Bus index sits right above the word index
   assign bus_idx = addr[`FB_SEL_LSB +: IDX_W];

   // Expand to one-hot
   always_comb
   begin
      sel = '0;
      sel[bus_idx] = 1'b1;
   end

endmodule

/* design/fb_map_pkg.sv */
// ******************************
// Address-map types
// Bus count must be a power of two
// ******************************
`include "fb_defines.svh"

package fb_map_pkg;

   // One bit per slave bus
   typedef logic [`FB_NBUS-1:0] fb_sel_t;

   // Bus number taken from the address
   typedef logic [$clog2(`FB_NBUS)-1:0] fb_bus_idx_t;

endpackage

/* design/fb_bus_pkg.sv */
// ******************************
// Frontend bus payloads
// A zero byte mask marks a read
// ******************************
`include "fb_defines.svh"

package fb_bus_pkg;

   // Command, 70 bits
   typedef struct packed {
      logic [`FB_AW-1:0]    addr;
      logic [`FB_DW-1:0]    wdata;
      logic [`FB_MW-1:0]    wmsk;
      logic [`FB_EXC_W-1:0] exc;
   } fb_req_t;

   // Response, 34 bits
   typedef struct packed {
      logic [`FB_DW-1:0]    rdata;
      logic [`FB_EXC_W-1:0] exc;
   } fb_rsp_t;

endpackage

/* design/fb_defines.svh */
// ******************************
// Fabric-wide widths and sizes
// Word index and bus index must fit below FB_AW
// ******************************
`ifndef FB_DEFINES_SVH
`define FB_DEFINES_SVH

// Core-side address and data widths
`define FB_AW        32
`define FB_DW        32
// One mask bit per data byte
`define FB_MW        (`FB_DW/8)
// Exception tag carried with every command
`define FB_EXC_W     2

// Four slave buses, selected by addr[9:8]
`define FB_NBUS      4
`define FB_SEL_LSB   8
// Words per slave, indexed by addr[7:2]
`define FB_MEM_WORDS 64

`endif
